// ==== bp_global_history.sv ====
`timescale 1ns/100ps

module bp_global_history (
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      spec_en_i,
    input  logic                      spec_bit_i,
    input  logic                      commit_en_i,
    input  logic                      commit_bit_i,
    input  logic                      repair_i,
    output logic [bp_pkg::HIST_W-1:0] spec_hist_o
);
    import bp_pkg::*;

    logic [HIST_W-1:0] spec_q;
    logic [HIST_W-1:0] commit_q;
    logic [HIST_W-1:0] commit_d;

    // committed value after this cycle's resolution
    always_comb begin
        commit_d = commit_q;
        if (commit_en_i) begin
            commit_d = {commit_q[HIST_W-2:0], commit_bit_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            commit_q <= '0;
        end else begin
            commit_q <= commit_d;
        end
    end

    // speculative copy, shifted at prediction time
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            spec_q <= '0;
        end else if (repair_i) begin
            // wrong path shifts are thrown away
            spec_q <= commit_d;
        end else if (spec_en_i) begin
            spec_q <= {spec_q[HIST_W-2:0], spec_bit_i};
        end
    end

    assign spec_hist_o = spec_q;

endmodule

// ==== bp_pattern_table.sv ====
`timescale 1ns/100ps

module bp_pattern_table (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic [bp_pkg::PHT_IDX_W-1:0] rd_idx_i,
    output logic                         rd_taken_o,
    input  logic                         upd_en_i,
    input  logic [bp_pkg::PHT_IDX_W-1:0] upd_idx_i,
    input  logic                         upd_taken_i
);
    import bp_pkg::*;

    // two-bit saturating counters, upper bit is the direction
    logic [1:0] cnt_q [PHT_ENTRIES];
    logic [1:0] upd_cnt;

    assign rd_taken_o = cnt_q[rd_idx_i][1];

    assign upd_cnt = cnt_q[upd_idx_i];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < PHT_ENTRIES; i++) begin
                cnt_q[i] <= 2'b00;
            end
        end else if (upd_en_i) begin
            // saturate at both ends
            if (upd_taken_i && upd_cnt != 2'b11) begin
                cnt_q[upd_idx_i] <= upd_cnt + 2'b01;
            end else if (!upd_taken_i && upd_cnt != 2'b00) begin
                cnt_q[upd_idx_i] <= upd_cnt - 2'b01;
            end
        end
    end

endmodule

// ==== bp_pkg.sv ====
package bp_pkg;

    // halfword program counter
    localparam int PC_W = 18;

    // global history bits folded into the table index
    localparam int HIST_W = 5;

    // pattern table geometry
    localparam int PHT_ENTRIES = 32;
    localparam int PHT_IDX_W   = 5;

    // return address stack
    localparam int RAS_DEPTH = 4;

    typedef logic [PC_W-1:0] pc_t;

    // correction code reported from execute
    typedef enum logic [1:0] {
        FIX_NONE      = 2'd0,
        FIX_NOT_TAKEN = 2'd1,
        FIX_TAKEN     = 2'd2,
        FIX_TARGET    = 2'd3
    } fix_e;

    // request from fetch, instruction kind already decoded into flags
    typedef struct packed {
        logic valid;
        pc_t  pc;
        pc_t  imm;
        logic compressed;
        logic is_jal;
        logic is_jalr;
        logic ras_push;
        logic ras_pop;
    } fetch_req_t;

    // prediction back to fetch
    typedef struct packed {
        logic taken;
        pc_t  target;
    } pred_t;

    // resolved outcome from execute
    typedef struct packed {
        logic taken;
        pc_t  target;
    } resolve_t;

    // shadow pipeline entry, hist is the snapshot used for the table index
    typedef struct packed {
        logic              valid;
        pc_t               pc;
        logic              compressed;
        logic              is_jump;
        logic              pred_taken;
        pc_t               pred_target;
        logic [HIST_W-1:0] hist;
    } stage_t;

endpackage

// ==== bp_resolve_pipe.sv ====
`timescale 1ns/100ps

module bp_resolve_pipe (
    input  logic                         clk_i,
    input  logic                         rst_i,
    input  logic                         stall_i,
    input  bp_pkg::fetch_req_t           req_i,
    input  bp_pkg::pred_t                pred_i,
    input  logic [bp_pkg::HIST_W-1:0]    hist_i,
    input  bp_pkg::resolve_t             res_i,
    output bp_pkg::fix_e                 fix_o,
    output logic                         upd_en_o,
    output logic [bp_pkg::PHT_IDX_W-1:0] upd_idx_o,
    output logic                         upd_taken_o,
    output logic                         repair_o
);
    import bp_pkg::*;

    stage_t new_entry;
    stage_t dec_q;
    stage_t ex_q;
    fix_e   fix;
    logic   squash;

    // snapshot of the request as predicted this cycle
    always_comb begin
        new_entry             = '0;
        new_entry.valid       = req_i.valid;
        new_entry.pc          = req_i.pc;
        new_entry.compressed  = req_i.compressed;
        new_entry.is_jump     = req_i.is_jal | req_i.is_jalr;
        new_entry.pred_taken  = pred_i.taken;
        new_entry.pred_target = pred_i.target;
        new_entry.hist        = hist_i;
    end

    // compare execute entry with the resolved outcome
    always_comb begin
        fix = FIX_NONE;
        if (ex_q.valid) begin
            if (ex_q.pred_taken && !res_i.taken) begin
                fix = FIX_NOT_TAKEN;
            end else if (!ex_q.pred_taken && res_i.taken) begin
                fix = FIX_TAKEN;
            end else if (ex_q.pred_taken && ex_q.pred_target != res_i.target) begin
                fix = FIX_TARGET;
            end
        end
    end

    assign fix_o = fix;

    // updates land on the edge that retires the execute entry
    assign squash = (fix != FIX_NONE) && !stall_i;

    assign repair_o    = squash;
    assign upd_en_o    = ex_q.valid && !ex_q.is_jump && !stall_i;
    assign upd_idx_o   = ex_q.pc[PHT_IDX_W:1] ^ ex_q.hist;
    assign upd_taken_o = res_i.taken;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_q.valid <= 1'b0;
            ex_q.valid  <= 1'b0;
        end else if (!stall_i) begin
            dec_q <= new_entry;
            ex_q  <= dec_q;
            // both younger slots are on the wrong path
            if (squash) begin
                dec_q.valid <= 1'b0;
                ex_q.valid  <= 1'b0;
            end
        end
    end

endmodule

// ==== bp_return_stack.sv ====
`timescale 1ns/100ps

module bp_return_stack (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        en_i,
    input  logic        push_i,
    input  logic        pop_i,
    input  bp_pkg::pc_t push_addr_i,
    output bp_pkg::pc_t top_o
);
    import bp_pkg::*;

    // entry 0 is the top
    pc_t stack_q [RAS_DEPTH];

    assign top_o = stack_q[0];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < RAS_DEPTH; i++) begin
                stack_q[i] <= '0;
            end
        end else if (en_i) begin
            if (push_i && pop_i) begin
                // return followed by call, top is replaced
                stack_q[0] <= push_addr_i;
            end else if (push_i) begin
                // oldest entry falls off the bottom
                for (int i = RAS_DEPTH - 1; i > 0; i--) begin
                    stack_q[i] <= stack_q[i-1];
                end
                stack_q[0] <= push_addr_i;
            end else if (pop_i) begin
                for (int i = 0; i < RAS_DEPTH - 1; i++) begin
                    stack_q[i] <= stack_q[i+1];
                end
                stack_q[RAS_DEPTH-1] <= '0;
            end
        end
    end

endmodule

// ==== branch_predictor.sv ====
`timescale 1ns/100ps

module branch_predictor (
    input  logic               clk_i,
    input  logic               rst_i,
    input  logic               stall_i,
    input  bp_pkg::fetch_req_t req_i,
    input  bp_pkg::resolve_t   res_i,
    output bp_pkg::pred_t      pred_o,
    output bp_pkg::fix_e       fix_o
);
    import bp_pkg::*;

    logic [PHT_IDX_W-1:0] rd_idx;
    logic [HIST_W-1:0]    spec_hist;
    logic                 pht_taken;
    logic                 is_jump;
    logic                 spec_valid;
    pc_t                  ret_addr;
    pc_t                  ras_top;
    pred_t                pred;

    logic                 upd_en;
    logic [PHT_IDX_W-1:0] upd_idx;
    logic                 upd_taken;
    logic                 repair;

    // gshare hash
    assign rd_idx = req_i.pc[PHT_IDX_W:1] ^ spec_hist;

    assign is_jump = req_i.is_jal | req_i.is_jalr;

    // halfword units
    assign ret_addr = req_i.pc + (req_i.compressed ? pc_t'(1) : pc_t'(2));

    always_comb begin
        pred.taken  = is_jump ? 1'b1 : pht_taken;
        pred.target = req_i.ras_pop ? ras_top : req_i.pc + req_i.imm;
    end

    assign pred_o = pred;

    // incoming request is dropped when execute repairs
    assign spec_valid = req_i.valid && !stall_i && !repair;

    bp_pattern_table u_pattern_table (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rd_idx_i   (rd_idx),
        .rd_taken_o (pht_taken),
        .upd_en_i   (upd_en),
        .upd_idx_i  (upd_idx),
        .upd_taken_i(upd_taken)
    );

    bp_return_stack u_return_stack (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .en_i       (spec_valid),
        .push_i     (req_i.ras_push),
        .pop_i      (req_i.ras_pop),
        .push_addr_i(ret_addr),
        .top_o      (ras_top)
    );

    bp_global_history u_global_history (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .spec_en_i   (spec_valid && !is_jump),
        .spec_bit_i  (pht_taken),
        .commit_en_i (upd_en),
        .commit_bit_i(upd_taken),
        .repair_i    (repair),
        .spec_hist_o (spec_hist)
    );

    bp_resolve_pipe u_resolve_pipe (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .stall_i    (stall_i),
        .req_i      (req_i),
        .pred_i     (pred),
        .hist_i     (spec_hist),
        .res_i      (res_i),
        .fix_o      (fix_o),
        .upd_en_o   (upd_en),
        .upd_idx_o  (upd_idx),
        .upd_taken_o(upd_taken),
        .repair_o   (repair)
    );

endmodule

// ==== flist.f ====
bp_pkg.sv
bp_pattern_table.sv
bp_return_stack.sv
bp_global_history.sv
bp_resolve_pipe.sv
branch_predictor.sv
tb_branch_predictor.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/100ps \
    -f flist.f \
    --top-module tb_branch_predictor \
    -o sim_tb

# the pipe keeps going on a failing run so the log decides
./obj_dir/sim_tb | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    echo "run_sim: passed"
else
    echo "run_sim: failed"
    exit 1
fi

// ==== tb_branch_predictor.sv ====
`timescale 1ns/100ps

module tb_branch_predictor;
    import bp_pkg::*;

    localparam int N_OPS       = 3000;
    localparam int WATCHDOG_NS = (N_OPS * 2 + 100) * 20;

    logic       clk_i = 1'b0;
    logic       rst_i;
    logic       stall_i;
    fetch_req_t req_i;
    resolve_t   res_i;
    pred_t      pred_o;
    fix_e       fix_o;

    // reference state
    logic [1:0]        m_cnt [PHT_ENTRIES];
    logic [HIST_W-1:0] m_spec;
    logic [HIST_W-1:0] m_commit;
    pc_t               m_ras [RAS_DEPTH];
    stage_t            m_dec;
    stage_t            m_ex;

    logic [15:0] lfsr_q = 16'd39246;
    int          fix_seen [4];

    branch_predictor u_branch_predictor (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .stall_i(stall_i),
        .req_i  (req_i),
        .res_i  (res_i),
        .pred_o (pred_o),
        .fix_o  (fix_o)
    );

    always #10 clk_i = ~clk_i;

    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit
    task automatic take_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
    endtask

    // few pcs so the counters see repeats
    // bit 1 of the pc sets the preferred direction
    function automatic pc_t pick_pc(logic [1:0] sel);
        case (sel)
            2'd0:    return 18'h00106;
            2'd1:    return 18'h00230;
            2'd2:    return 18'h0104a;
            default: return 18'h20014;
        endcase
    endfunction

    function automatic pred_t expected_pred(fetch_req_t r);
        pred_t p;
        logic [PHT_IDX_W-1:0] idx;
        idx = r.pc[PHT_IDX_W:1] ^ m_spec;
        p.taken = (r.is_jal || r.is_jalr) ? 1'b1 : m_cnt[idx][1];
        if (r.ras_pop) begin
            p.target = m_ras[0];
        end else begin
            p.target = r.pc + r.imm;
        end
        return p;
    endfunction

    function automatic fix_e expected_fix(stage_t e, resolve_t r);
        if (!e.valid) begin
            return FIX_NONE;
        end
        if (e.pred_taken != r.taken) begin
            return r.taken ? FIX_TAKEN : FIX_NOT_TAKEN;
        end
        if (r.taken && (r.target != e.pred_target)) begin
            return FIX_TARGET;
        end
        return FIX_NONE;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < PHT_ENTRIES; i++) begin
            m_cnt[i] = 2'b00;
        end
        for (int i = 0; i < RAS_DEPTH; i++) begin
            m_ras[i] = '0;
        end
        m_spec   = '0;
        m_commit = '0;
        m_dec    = '0;
        m_ex     = '0;
    endtask

    // state the DUT will hold after the next rising edge
    task automatic advance_model(input pred_t p, input fix_e f);
        logic [HIST_W-1:0]    commit_n;
        logic [PHT_IDX_W-1:0] idx;
        stage_t               e;
        logic                 squash;
        if (!stall_i) begin
            squash   = (f != FIX_NONE);
            commit_n = m_commit;
            if (m_ex.valid && !m_ex.is_jump) begin
                idx = m_ex.pc[PHT_IDX_W:1] ^ m_ex.hist;
                if (res_i.taken && m_cnt[idx] != 2'b11) begin
                    m_cnt[idx] = m_cnt[idx] + 2'b01;
                end else if (!res_i.taken && m_cnt[idx] != 2'b00) begin
                    m_cnt[idx] = m_cnt[idx] - 2'b01;
                end
                commit_n = {m_commit[HIST_W-2:0], res_i.taken};
            end
            e             = '0;
            e.valid       = req_i.valid;
            e.pc          = req_i.pc;
            e.compressed  = req_i.compressed;
            e.is_jump     = req_i.is_jal || req_i.is_jalr;
            e.pred_taken  = p.taken;
            e.pred_target = p.target;
            e.hist        = m_spec;
            if (squash) begin
                m_spec = commit_n;
            end else if (req_i.valid && !e.is_jump) begin
                m_spec = {m_spec[HIST_W-2:0], p.taken};
            end
            m_commit = commit_n;
            if (req_i.valid && !squash) begin
                if (req_i.ras_push && req_i.ras_pop) begin
                    m_ras[0] = req_i.pc + (req_i.compressed ? pc_t'(1) : pc_t'(2));
                end else if (req_i.ras_push) begin
                    for (int i = RAS_DEPTH - 1; i > 0; i--) begin
                        m_ras[i] = m_ras[i-1];
                    end
                    m_ras[0] = req_i.pc + (req_i.compressed ? pc_t'(1) : pc_t'(2));
                end else if (req_i.ras_pop) begin
                    for (int i = 0; i < RAS_DEPTH - 1; i++) begin
                        m_ras[i] = m_ras[i+1];
                    end
                    m_ras[RAS_DEPTH-1] = '0;
                end
            end
            m_ex  = m_dec;
            m_dec = e;
            if (squash) begin
                m_ex.valid  = 1'b0;
                m_dec.valid = 1'b0;
            end
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic compare_and_step();
        pred_t p;
        fix_e  f;
        p = expected_pred(req_i);
        f = expected_fix(m_ex, res_i);
        check("pred_o.taken", 32'(pred_o.taken), 32'(p.taken));
        check("pred_o.target", 32'(pred_o.target), 32'(p.target));
        check("fix_o", 32'(fix_o), 32'(f));
        check("spec_hist", 32'(u_branch_predictor.spec_hist), 32'(m_spec));
        fix_seen[f] = fix_seen[f] + 1;
        advance_model(p, f);
    endtask

    // outputs are settled half a period after the drive edge
    always @(negedge clk_i) begin
        if (rst_i) begin
            reset_model();
        end else begin
            compare_and_step();
        end
    end

    task automatic drive_request();
        logic [15:0] b;
        fetch_req_t  r;
        resolve_t    s;
        logic        dir;
        logic        held;
        // execute entry did not move on this edge
        held = stall_i;
        r = '0;
        take_bits(3, b);
        stall_i <= (b[2:0] == 3'd0);
        take_bits(4, b);
        r.valid = (b[3:0] != 4'd0);
        take_bits(2, b);
        r.pc = pick_pc(b[1:0]);
        take_bits(8, b);
        r.imm = pc_t'(b[7:0]);
        take_bits(3, b);
        r.is_jal  = (b[2:0] == 3'd0);
        r.is_jalr = (b[2:0] == 3'd1);
        take_bits(1, b);
        r.compressed = b[0];
        take_bits(2, b);
        r.ras_push = (b[1:0] == 2'd0);
        take_bits(2, b);
        r.ras_pop = (b[1:0] == 2'd0);
        req_i <= r;
        // outcome for the entry sitting in execute after this edge
        take_bits(3, b);
        if (b[2:0] < 3'd5) begin
            dir = m_ex.pred_taken;
        end else if (b[2:0] < 3'd7) begin
            dir = m_ex.pc[1];
        end else begin
            dir = !m_ex.pred_taken;
        end
        take_bits(2, b);
        s.taken = dir;
        if (dir && m_ex.pred_taken && b[1:0] != 2'd0) begin
            s.target = m_ex.pred_target;
        end else begin
            s.target = m_ex.pc + pc_t'(b[1:0]) + pc_t'(3);
        end
        // a frozen execute stage keeps its outcome
        if (!held) begin
            res_i <= s;
        end
    endtask

    initial begin
        int missing;
        rst_i   = 1'b1;
        stall_i = 1'b0;
        req_i   = '0;
        res_i   = '0;
        for (int i = 0; i < 4; i++) begin
            fix_seen[i] = 0;
        end
        repeat (16) @(posedge clk_i);
        rst_i <= 1'b0;
        for (int n = 0; n < N_OPS; n++) begin
            drive_request();
            @(posedge clk_i);
        end
        req_i   <= '0;
        res_i   <= '0;
        stall_i <= 1'b0;
        repeat (4) @(posedge clk_i);
        missing = 0;
        for (int c = 1; c < 4; c++) begin
            if (fix_seen[c] == 0) begin
                $display("correction code %0d never occurred during the run", c);
                missing++;
            end
        end
        if (missing == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "run ended with errors");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the stimulus finished");
        $display("Simulation finished: FAIL");
        $fatal(1, "timeout");
    end

endmodule
